/* trace_export_cfg.svh */
// Configuration macros for the trace and event export block
`ifndef TRACE_EXPORT_CFG_SVH
`define TRACE_EXPORT_CFG_SVH

// --------------------------------------------------
// Cluster
// --------------------------------------------------

// Harts feeding events and traces
`define TE_NUM_HARTS 2

// --------------------------------------------------
// Event CDC FIFO
// --------------------------------------------------

// Four slots, pointers carry one extra wrap bit
`define TE_LOG_DEPTH 2
// Read pointer synchronizer depth
`define TE_SYNC_STAGES 3

// --------------------------------------------------
// Field widths
// --------------------------------------------------

`define TE_PC_WIDTH 64
`define TE_EID_WIDTH 8
`define TE_EINFO_WIDTH 32
`define TE_META_WIDTH 4
// Watermark and lost-event counters
`define TE_CNT_WIDTH 16

`endif

/* trace_export_pkg.sv */
// Event, trace and formatted record types plus gray pointer conversion
`include "trace_export_cfg.svh"

package trace_export_pkg;

  // Performance event as pushed into the CDC FIFO
  typedef struct packed {
    logic [`TE_EID_WIDTH-1:0]   e_id;
    logic [`TE_EINFO_WIDTH-1:0] e_info;
    logic [3:0]                 s_id;
  } pmu_event_t;

  // Branch source with its valid flag
  typedef struct packed {
    logic                    v;
    logic [`TE_PC_WIDTH-1:0] pc;
  } trace_src_t;

  typedef struct packed {
    logic [`TE_PC_WIDTH-1:0] pc;
  } trace_tgt_t;

  // Record as seen by the snooper interrupt logic
  typedef struct packed {
    logic [1:0]  priv_lvl;
    logic [31:0] pc_src_h;
    logic [31:0] pc_src_l;
    logic [31:0] pc_dst_h;
    logic [31:0] pc_dst_l;
    logic [31:0] metadata;
    logic [31:0] opcode;
    logic        pc_v;
  } trace_rec_t;

  typedef logic [`TE_LOG_DEPTH:0] ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // MSB passes through, each lower bit folds in the one above
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin = gray;
    for (int i = `TE_LOG_DEPTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* event_cdc_src.sv */
// Source half of a gray pointer CDC FIFO with event filter and drop pulse
`timescale 1ns/1ps
`include "trace_export_cfg.svh"

module event_cdc_src #(
  parameter type T           = trace_export_pkg::pmu_event_t,
  parameter int  LOG_DEPTH   = `TE_LOG_DEPTH,
  parameter int  SYNC_STAGES = `TE_SYNC_STAGES
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  T                       data_i,
  input  logic [LOG_DEPTH:0]     evt_rptr_i,
  output logic [LOG_DEPTH:0]     evt_wptr_o,
  output T [2**LOG_DEPTH-1:0]    evt_data_o,
  output logic                   drop_o
);

  localparam int DEPTH = 2**LOG_DEPTH;
  localparam int PTR_W = LOG_DEPTH + 1;
  // Gray full pattern has the top two bits inverted
  localparam logic [PTR_W-1:0] FULL_MASK = PTR_W'(3) << (LOG_DEPTH - 1);

  logic [PTR_W-1:0]                   wptr_gray_q;
  logic [PTR_W-1:0]                   wptr_bin;
  logic [SYNC_STAGES-1:0][PTR_W-1:0]  rptr_sync_q;
  logic [PTR_W-1:0]                   rptr_sync;
  logic [PTR_W-1:0]                   rptr_sync_bin;
  logic [PTR_W-1:0]                   fill_level;
  T [DEPTH-1:0]                       mem_q;
  logic                               evt_valid;
  logic                               full;
  logic                               push;
  logic                               drop_q;

  // --------------------------------------------------
  // Push filter and full detection
  // --------------------------------------------------

  // Event ID zero means no event this cycle
  assign evt_valid = |data_i.e_id;

  assign wptr_bin      = trace_export_pkg::gray2bin(wptr_gray_q);
  assign rptr_sync     = rptr_sync_q[SYNC_STAGES-1];
  assign rptr_sync_bin = trace_export_pkg::gray2bin(rptr_sync);
  assign fill_level    = wptr_bin - rptr_sync_bin;

  assign full = (wptr_gray_q == (rptr_sync ^ FULL_MASK));
  assign push = evt_valid & ~full;

  // --------------------------------------------------
  // Pointers
  // --------------------------------------------------

  // Read pointer arrives from the other domain
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_sync_q <= '0;
    end else begin
      rptr_sync_q[0] <= evt_rptr_i;
      for (int s = 1; s < SYNC_STAGES; s++) begin
        rptr_sync_q[s] <= rptr_sync_q[s-1];
      end
    end
  end

  // Gray pointer kept in a flop so the crossing sees one bit change
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_gray_q <= '0;
      drop_q      <= 1'b0;
    end else begin
      if (push) begin
        wptr_gray_q <= trace_export_pkg::bin2gray(wptr_bin + PTR_W'(1));
      end
      drop_q <= evt_valid & full;
    end
  end

  // Slot storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_bin[LOG_DEPTH-1:0]] <= data_i;
    end
  end

  assign evt_wptr_o = wptr_gray_q;
  assign evt_data_o = mem_q;
  assign drop_o     = drop_q;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Binary fill level at depth must freeze the gray write pointer
  a_hold_when_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (fill_level == PTR_W'(DEPTH)) |=> $stable(wptr_gray_q)
  ) else $error("event_cdc_src: write pointer advanced while full");

  // Reader side may lag but never overtake the writer
  a_rptr_behind_wptr: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    fill_level <= PTR_W'(DEPTH)
  ) else $error("event_cdc_src: read pointer passed write pointer");

endmodule

/* trace_formatter.sv */
// Trace record formatter with hart selection and one registered record per cycle
`timescale 1ns/1ps
`include "trace_export_cfg.svh"

module trace_formatter (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  logic                                               core_select_i,
  input  trace_export_pkg::trace_src_t [`TE_NUM_HARTS-1:0]   trace_src_i,
  input  trace_export_pkg::trace_tgt_t [`TE_NUM_HARTS-1:0]   trace_tgt_i,
  input  logic [`TE_NUM_HARTS-1:0][`TE_META_WIDTH-1:0]       trace_meta_i,
  input  logic [`TE_NUM_HARTS-1:0][1:0]                      priv_lvl_i,
  input  logic [`TE_NUM_HARTS-1:0][31:0]                     opcode_i,
  output trace_export_pkg::trace_rec_t                       rec_o,
  output logic                                               rec_valid_o
);

  trace_export_pkg::trace_src_t src_sel;
  trace_export_pkg::trace_tgt_t tgt_sel;
  trace_export_pkg::trace_rec_t rec_d;
  trace_export_pkg::trace_rec_t rec_q;
  logic                         rec_valid_q;

  // --------------------------------------------------
  // Hart selection
  // --------------------------------------------------

  assign src_sel = trace_src_i[core_select_i];
  assign tgt_sel = trace_tgt_i[core_select_i];

  // Split PCs into 32-bit words, bit 63 and bit 0 dropped
  always_comb begin
    rec_d.priv_lvl = priv_lvl_i[core_select_i];
    rec_d.pc_src_h = {1'b0, src_sel.pc[62:32]};
    rec_d.pc_src_l = {src_sel.pc[31:1], 1'b0};
    rec_d.pc_dst_h = {1'b0, tgt_sel.pc[62:32]};
    rec_d.pc_dst_l = {tgt_sel.pc[31:1], 1'b0};
    rec_d.metadata = 32'(trace_meta_i[core_select_i]);
    rec_d.opcode   = opcode_i[core_select_i];
    rec_d.pc_v     = src_sel.v;
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    rec_q <= rec_d;
  end

  // Valid follows the source flag of the chosen hart
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_valid_q <= 1'b0;
    end else begin
      rec_valid_q <= src_sel.v;
    end
  end

  assign rec_o       = rec_q;
  assign rec_valid_o = rec_valid_q;

endmodule

/* trace_irq_unit.sv */
// Snooper interrupts from the trace stream plus the lost event counter
`timescale 1ns/1ps
`include "trace_export_cfg.svh"

module trace_irq_unit (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  trace_export_pkg::trace_rec_t  rec_i,
  input  logic                          rec_valid_i,
  input  logic [`TE_NUM_HARTS-1:0]      drop_i,
  input  logic [`TE_CNT_WIDTH-1:0]      watermark_i,
  input  logic [`TE_PC_WIDTH-1:0]       trigger_addr_i,
  input  logic                          irq_clear_i,
  output logic                          watermark_irq_o,
  output logic                          trigger_irq_o,
  output logic [`TE_CNT_WIDTH-1:0]      lost_count_o
);

  logic [`TE_CNT_WIDTH-1:0] rec_cnt_q;
  logic [`TE_CNT_WIDTH-1:0] rec_cnt_d;
  logic [`TE_PC_WIDTH-1:0]  dst_pc;
  logic                     wm_hit;
  logic                     trig_hit;
  logic                     wm_irq_q;
  logic                     trig_irq_q;
  logic [`TE_CNT_WIDTH:0]   lost_sum;
  logic [`TE_CNT_WIDTH-1:0] lost_q;

  // --------------------------------------------------
  // Watermark
  // --------------------------------------------------

  // Count saturates rather than wrapping back under the watermark
  assign rec_cnt_d = (rec_valid_i && rec_cnt_q != '1) ? rec_cnt_q + 1'b1 : rec_cnt_q;

  // Fires on the edge that brings the count to the watermark
  assign wm_hit = rec_valid_i && (watermark_i != '0) && (rec_cnt_d == watermark_i);

  // Words already hold bit 63 and bit 0 as zero
  assign dst_pc   = {rec_i.pc_dst_h, rec_i.pc_dst_l};
  assign trig_hit = rec_valid_i && (dst_pc == trigger_addr_i);

  // Interrupts stay up until software clears them
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_cnt_q  <= '0;
      wm_irq_q   <= 1'b0;
      trig_irq_q <= 1'b0;
    end else if (irq_clear_i) begin
      rec_cnt_q  <= '0;
      wm_irq_q   <= 1'b0;
      trig_irq_q <= 1'b0;
    end else begin
      rec_cnt_q  <= rec_cnt_d;
      wm_irq_q   <= wm_irq_q | wm_hit;
      trig_irq_q <= trig_irq_q | trig_hit;
    end
  end

  // --------------------------------------------------
  // Lost events
  // --------------------------------------------------

  // One extra bit catches the carry for saturation
  always_comb begin
    lost_sum = {1'b0, lost_q};
    for (int h = 0; h < `TE_NUM_HARTS; h++) begin
      lost_sum = lost_sum + drop_i[h];
    end
  end

  // Not touched by irq_clear_i
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lost_q <= '0;
    end else begin
      lost_q <= lost_sum[`TE_CNT_WIDTH] ? '1 : lost_sum[`TE_CNT_WIDTH-1:0];
    end
  end

  assign watermark_irq_o = wm_irq_q;
  assign trigger_irq_o   = trig_irq_q;
  assign lost_count_o    = lost_q;

  a_lost_monotonic: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    lost_count_o >= $past(lost_count_o)
  ) else $error("trace_irq_unit: lost event count decreased");

endmodule

/* trace_export_top.sv */
// Trace and event export top with per-hart exporters, formatter and IRQ unit
`timescale 1ns/1ps
`include "trace_export_cfg.svh"

module trace_export_top (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,

  // Per-hart event and trace inputs
  input  trace_export_pkg::pmu_event_t [`TE_NUM_HARTS-1:0]    event_i,
  input  trace_export_pkg::trace_src_t [`TE_NUM_HARTS-1:0]    trace_src_i,
  input  trace_export_pkg::trace_tgt_t [`TE_NUM_HARTS-1:0]    trace_tgt_i,
  input  logic [`TE_NUM_HARTS-1:0][`TE_META_WIDTH-1:0]        trace_meta_i,
  input  logic [`TE_NUM_HARTS-1:0][1:0]                       priv_lvl_i,
  input  logic [`TE_NUM_HARTS-1:0][31:0]                      opcode_i,

  // Snooper configuration levels
  input  logic                                                core_select_i,
  input  logic [`TE_CNT_WIDTH-1:0]                            watermark_i,
  input  logic [`TE_PC_WIDTH-1:0]                             trigger_addr_i,
  input  logic                                                irq_clear_i,

  // Event FIFOs toward the reader domain
  input  logic [`TE_NUM_HARTS-1:0][`TE_LOG_DEPTH:0]           evt_rptr_i,
  output logic [`TE_NUM_HARTS-1:0][`TE_LOG_DEPTH:0]           evt_wptr_o,
  output trace_export_pkg::pmu_event_t
         [`TE_NUM_HARTS-1:0][2**`TE_LOG_DEPTH-1:0]            evt_data_o,

  // Formatted trace and interrupts
  output trace_export_pkg::trace_rec_t                        trace_rec_o,
  output logic                                                trace_valid_o,
  output logic                                                watermark_irq_o,
  output logic                                                trigger_irq_o,
  output logic [`TE_CNT_WIDTH-1:0]                            lost_count_o
);

  logic [`TE_NUM_HARTS-1:0] evt_drop;

  // --------------------------------------------------
  // Event export, one FIFO per hart
  // --------------------------------------------------

  for (genvar h = 0; h < `TE_NUM_HARTS; h++) begin : gen_exporter
    event_cdc_src #(
      .T           ( trace_export_pkg::pmu_event_t ),
      .LOG_DEPTH   ( `TE_LOG_DEPTH                 ),
      .SYNC_STAGES ( `TE_SYNC_STAGES               )
    ) u_event_cdc_src (
      .clk_i      ( clk_i         ),
      .arst_n_i   ( arst_n_i      ),
      .data_i     ( event_i[h]    ),
      .evt_rptr_i ( evt_rptr_i[h] ),
      .evt_wptr_o ( evt_wptr_o[h] ),
      .evt_data_o ( evt_data_o[h] ),
      .drop_o     ( evt_drop[h]   )
    );
  end

  // --------------------------------------------------
  // Trace formatting
  // --------------------------------------------------

  trace_formatter u_trace_formatter (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .core_select_i ( core_select_i ),
    .trace_src_i   ( trace_src_i   ),
    .trace_tgt_i   ( trace_tgt_i   ),
    .trace_meta_i  ( trace_meta_i  ),
    .priv_lvl_i    ( priv_lvl_i    ),
    .opcode_i      ( opcode_i      ),
    .rec_o         ( trace_rec_o   ),
    .rec_valid_o   ( trace_valid_o )
  );

  // --------------------------------------------------
  // Interrupts and lost events
  // --------------------------------------------------

  // Sees the same registered record that leaves the top
  trace_irq_unit u_trace_irq_unit (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .rec_i           ( trace_rec_o     ),
    .rec_valid_i     ( trace_valid_o   ),
    .drop_i          ( evt_drop        ),
    .watermark_i     ( watermark_i     ),
    .trigger_addr_i  ( trigger_addr_i  ),
    .irq_clear_i     ( irq_clear_i     ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   ),
    .lost_count_o    ( lost_count_o    )
  );

endmodule

/* tb_trace_export.sv */
// Testbench for the trace export top with FIFO reader model, reference functions and checks
`timescale 1ns/1ps
`include "trace_export_cfg.svh"

module tb_trace_export;

  localparam int ORDER_EVTS = 24;
  localparam int DRAIN_MAX  = 32;
  localparam int FMT_CYCLES = 40;
  localparam int WM_LEVEL   = 5;
  localparam int WM_CYCLES  = 16;
  localparam int TRIG_STEPS = 10;
  // Cycles driven by reset and all five tests
  localparam int STIM_CYCLES = 8 + (ORDER_EVTS * 3 + DRAIN_MAX) + (14 + DRAIN_MAX + 5)
                             + (FMT_CYCLES + 2) + 2 * (WM_CYCLES + 4) + (TRIG_STEPS + 8);
  localparam int WATCHDOG_CYCLES = STIM_CYCLES * 2 + 200;

  logic                                                    clk_i;
  logic                                                    arst_n_i;
  trace_export_pkg::pmu_event_t [`TE_NUM_HARTS-1:0]        event_i;
  trace_export_pkg::trace_src_t [`TE_NUM_HARTS-1:0]        trace_src_i;
  trace_export_pkg::trace_tgt_t [`TE_NUM_HARTS-1:0]        trace_tgt_i;
  logic [`TE_NUM_HARTS-1:0][`TE_META_WIDTH-1:0]            trace_meta_i;
  logic [`TE_NUM_HARTS-1:0][1:0]                           priv_lvl_i;
  logic [`TE_NUM_HARTS-1:0][31:0]                          opcode_i;
  logic                                                    core_select_i;
  logic [`TE_CNT_WIDTH-1:0]                                watermark_i;
  logic [`TE_PC_WIDTH-1:0]                                 trigger_addr_i;
  logic                                                    irq_clear_i;
  logic [`TE_NUM_HARTS-1:0][`TE_LOG_DEPTH:0]               evt_rptr_i;
  logic [`TE_NUM_HARTS-1:0][`TE_LOG_DEPTH:0]               evt_wptr_o;
  trace_export_pkg::pmu_event_t
        [`TE_NUM_HARTS-1:0][2**`TE_LOG_DEPTH-1:0]          evt_data_o;
  trace_export_pkg::trace_rec_t                            trace_rec_o;
  logic                                                    trace_valid_o;
  logic                                                    watermark_irq_o;
  logic                                                    trigger_irq_o;
  logic [`TE_CNT_WIDTH-1:0]                                lost_count_o;

  integer                       seed;
  int                           errors;
  int                           tests_failed;
  logic                         reader_run;
  logic                         fmt_chk_en;
  logic [`TE_LOG_DEPTH:0]       wr_bin [`TE_NUM_HARTS];
  logic [`TE_LOG_DEPTH:0]       rd_bin [`TE_NUM_HARTS];
  int                           rd_cnt [`TE_NUM_HARTS];
  trace_export_pkg::pmu_event_t exp_q [`TE_NUM_HARTS][$];

  trace_export_top u_trace_export_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Helpers and reference functions
  // --------------------------------------------------

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [63:0] rand_pc();
    return {rand32(), rand32()};
  endfunction

  function automatic logic [`TE_LOG_DEPTH:0] to_gray(input logic [`TE_LOG_DEPTH:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic trace_export_pkg::pmu_event_t rand_event(input logic valid);
    trace_export_pkg::pmu_event_t ev;
    logic [31:0]                  r;
    r = rand32();
    ev.e_id   = valid ? ((r[7:0] == 8'h00) ? 8'h01 : r[7:0]) : 8'h00;
    ev.s_id   = r[11:8];
    ev.e_info = rand32();
    return ev;
  endfunction

  // Record rule: PC bits 62..32 and 31..1 as words, metadata zero-extended
  function automatic trace_export_pkg::trace_rec_t format_ref(
    input trace_export_pkg::trace_src_t src, input trace_export_pkg::trace_tgt_t tgt,
    input logic [`TE_META_WIDTH-1:0] meta, input logic [1:0] priv, input logic [31:0] opc);
    trace_export_pkg::trace_rec_t r;
    r.priv_lvl = priv;
    r.pc_src_h = {1'b0, src.pc[62:32]};
    r.pc_src_l = {src.pc[31:1], 1'b0};
    r.pc_dst_h = {1'b0, tgt.pc[62:32]};
    r.pc_dst_l = {tgt.pc[31:1], 1'b0};
    r.metadata = {{(32 - `TE_META_WIDTH){1'b0}}, meta};
    r.opcode   = opc;
    r.pc_v     = src.v;
    return r;
  endfunction

  function automatic logic trigger_ref(input trace_export_pkg::trace_rec_t rec,
                                       input logic [63:0] addr);
    return rec.pc_v && ({rec.pc_dst_h, rec.pc_dst_l} == addr);
  endfunction

  function automatic trace_export_pkg::trace_rec_t sel_rec();
    return format_ref(trace_src_i[core_select_i], trace_tgt_i[core_select_i],
                      trace_meta_i[core_select_i], priv_lvl_i[core_select_i],
                      opcode_i[core_select_i]);
  endfunction

  task automatic mismatch(input string name, input logic [255:0] got, input logic [255:0] exp);
    $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic error_msg(input string what);
    $display("error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic report(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------
  // FIFO reader model, one slot per cycle when running
  // --------------------------------------------------

  task automatic read_one(input int h);
    trace_export_pkg::pmu_event_t got;
    trace_export_pkg::pmu_event_t exp;
    if (evt_wptr_o[h] != to_gray(rd_bin[h])) begin
      got = evt_data_o[h][rd_bin[h][`TE_LOG_DEPTH-1:0]];
      if (exp_q[h].size() == 0) begin
        error_msg($sformatf("hart %0d FIFO holds an event that was never pushed", h));
      end else begin
        exp = exp_q[h].pop_front();
        if (got !== exp)
          mismatch($sformatf("evt_data_o[%0d]", h), got, exp);
      end
      rd_bin[h]     = rd_bin[h] + 1'b1;
      rd_cnt[h]     = rd_cnt[h] + 1;
      evt_rptr_i[h] = to_gray(rd_bin[h]);
    end
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    for (int h = 0; h < `TE_NUM_HARTS; h++) begin
      if (reader_run)
        read_one(h);
    end
  endtask

  task automatic check_wptrs();
    for (int h = 0; h < `TE_NUM_HARTS; h++) begin
      if (evt_wptr_o[h] !== to_gray(wr_bin[h]))
        mismatch($sformatf("evt_wptr_o[%0d]", h), evt_wptr_o[h], to_gray(wr_bin[h]));
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    reader_run = 1'b1;
    while ((exp_q[0].size() + exp_q[1].size()) != 0 && waited < DRAIN_MAX) begin
      next_cycle();
      waited++;
    end
    if ((exp_q[0].size() + exp_q[1].size()) != 0)
      error_msg("pushed events did not come out of the FIFOs in time");
  endtask

  task automatic drive_hart(input int h, input logic v, input logic [63:0] tgt);
    logic [31:0] r;
    r = rand32();
    trace_src_i[h].v   = v;
    trace_src_i[h].pc  = rand_pc();
    trace_tgt_i[h].pc  = tgt;
    trace_meta_i[h]    = r[`TE_META_WIDTH-1:0];
    priv_lvl_i[h]      = r[5:4];
    opcode_i[h]        = rand32();
  endtask

  // Selected hart gets v and tgt, the other one random content
  task automatic drive_trace(input logic v, input logic [63:0] tgt);
    logic [31:0] r;
    r = rand32();
    core_select_i = r[0];
    for (int h = 0; h < `TE_NUM_HARTS; h++) begin
      if (h == int'(core_select_i))
        drive_hart(h, v, tgt);
      else
        drive_hart(h, r[h+1], rand_pc());
    end
  endtask

  task automatic clear_irqs();
    next_cycle();
    drive_trace(1'b0, rand_pc());
    next_cycle();
    irq_clear_i = 1'b1;
    drive_trace(1'b0, rand_pc());
    next_cycle();
    irq_clear_i = 1'b0;
    drive_trace(1'b0, rand_pc());
    next_cycle();
    if (watermark_irq_o !== 1'b0 || trigger_irq_o !== 1'b0)
      error_msg("interrupts still high after irq_clear_i");
  endtask

  // Formatter compare, expectation taken at the capturing edge
  initial begin : fmt_compare
    trace_export_pkg::trace_rec_t exp_rec;
    logic                         chk;
    forever begin
      @(posedge clk_i);
      exp_rec = sel_rec();
      chk     = fmt_chk_en;
      @(negedge clk_i);
      if (chk && trace_rec_o !== exp_rec)
        mismatch("trace_rec_o", trace_rec_o, exp_rec);
      if (chk && trace_valid_o !== exp_rec.pc_v)
        mismatch("trace_valid_o", trace_valid_o, exp_rec.pc_v);
    end
  end

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic run_event_order();
    int                       errs0;
    logic [`TE_CNT_WIDTH-1:0] lost0;
    trace_export_pkg::pmu_event_t ev;
    errs0 = errors;
    lost0 = lost_count_o;
    reader_run = 1'b1;
    // One valid event every third cycle keeps the FIFO from filling
    for (int i = 0; i < ORDER_EVTS * 3; i++) begin
      next_cycle();
      check_wptrs();
      for (int h = 0; h < `TE_NUM_HARTS; h++) begin
        ev = rand_event(i % 3 == 0);
        event_i[h] = ev;
        if (ev.e_id != 8'h00) begin
          exp_q[h].push_back(ev);
          wr_bin[h] = wr_bin[h] + 1'b1;
        end
      end
    end
    event_i = '0;
    drain();
    check_wptrs();
    if (lost_count_o !== lost0)
      mismatch("lost_count_o", lost_count_o, lost0);
    report("event order", errs0);
  endtask

  task automatic run_back_pressure();
    int                       errs0;
    logic [`TE_CNT_WIDTH-1:0] lost0;
    logic [`TE_CNT_WIDTH-1:0] lost_exp;
    trace_export_pkg::pmu_event_t ev;
    errs0 = errors;
    reader_run = 1'b0;
    repeat (5) next_cycle();
    lost0 = lost_count_o;
    for (int i = 0; i < 9; i++) begin
      next_cycle();
      check_wptrs();
      // Events 4 and 5 of both harts are lost, each two cycles later
      lost_exp = lost0 + 2 * ((i >= 6) + (i >= 7));
      if (lost_count_o !== lost_exp)
        mismatch("lost_count_o", lost_count_o, lost_exp);
      for (int h = 0; h < `TE_NUM_HARTS; h++) begin
        ev = rand_event(i < 6);
        event_i[h] = ev;
        if (i < 4) begin
          exp_q[h].push_back(ev);
          wr_bin[h] = wr_bin[h] + 1'b1;
        end
      end
    end
    event_i = '0;
    rd_cnt = '{default: 0};
    drain();
    repeat (5) next_cycle();
    for (int h = 0; h < `TE_NUM_HARTS; h++) begin
      if (rd_cnt[h] != 2**`TE_LOG_DEPTH)
        error_msg($sformatf("hart %0d drained %0d events instead of 4", h, rd_cnt[h]));
    end
    report("back-pressure", errs0);
  endtask

  task automatic run_formatting();
    int          errs0;
    logic [31:0] r;
    errs0 = errors;
    for (int i = 0; i < FMT_CYCLES; i++) begin
      next_cycle();
      r = rand32();
      drive_trace(r[0], rand_pc());
    end
    repeat (2) next_cycle();
    report("formatting", errs0);
  endtask

  task automatic watermark_phase();
    int          cnt;
    int          hist1;
    int          hist2;
    logic        v;
    logic [31:0] r;
    cnt   = 0;
    hist1 = 0;
    hist2 = 0;
    for (int i = 0; i < WM_CYCLES; i++) begin
      next_cycle();
      // Interrupt reflects records driven two cycles back
      if (watermark_irq_o !== (hist2 >= WM_LEVEL))
        mismatch("watermark_irq_o", watermark_irq_o, hist2 >= WM_LEVEL);
      r = rand32();
      v = (r[1:0] != 2'b00);
      drive_trace(v, rand_pc());
      cnt   = cnt + int'(v);
      hist2 = hist1;
      hist1 = cnt;
    end
    if (hist2 < WM_LEVEL)
      error_msg("watermark level was never reached");
  endtask

  task automatic run_watermark();
    int errs0;
    errs0 = errors;
    trigger_addr_i = 64'h1;
    watermark_i    = WM_LEVEL;
    clear_irqs();
    watermark_phase();
    clear_irqs();
    watermark_phase();
    report("watermark", errs0);
  endtask

  task automatic run_trigger();
    int          errs0;
    int          kind [TRIG_STEPS] = '{1, 0, 0, 2, 0, 0, 3, 0, 0, 0};
    logic [63:0] addr;
    logic        hit1;
    logic        hit2;
    logic        sticky;
    errs0 = errors;
    addr  = rand_pc();
    addr[63] = 1'b0;
    addr[0]  = 1'b0;
    trigger_addr_i = addr;
    watermark_i    = '0;
    clear_irqs();
    hit1   = 1'b0;
    hit2   = 1'b0;
    sticky = 1'b0;
    // Invalid match, valid miss, then a valid match
    for (int i = 0; i < TRIG_STEPS; i++) begin
      next_cycle();
      sticky = sticky | hit2;
      if (trigger_irq_o !== sticky)
        mismatch("trigger_irq_o", trigger_irq_o, sticky);
      case (kind[i])
        1:       drive_trace(1'b0, addr);
        2:       drive_trace(1'b1, addr ^ 64'h100);
        3:       drive_trace(1'b1, addr);
        default: drive_trace(1'b0, rand_pc());
      endcase
      hit2 = hit1;
      hit1 = trigger_ref(sel_rec(), addr);
    end
    if (!sticky)
      error_msg("trigger interrupt was never raised");
    clear_irqs();
    report("trigger", errs0);
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------

  initial begin
    seed           = 32'h66e256f6;
    errors         = 0;
    tests_failed   = 0;
    reader_run     = 1'b0;
    fmt_chk_en     = 1'b0;
    wr_bin         = '{default: '0};
    rd_bin         = '{default: '0};
    rd_cnt         = '{default: 0};
    arst_n_i       = 1'b0;
    event_i        = '0;
    trace_src_i    = '0;
    trace_tgt_i    = '0;
    trace_meta_i   = '0;
    priv_lvl_i     = '0;
    opcode_i       = '0;
    core_select_i  = 1'b0;
    watermark_i    = '0;
    trigger_addr_i = 64'h1;
    irq_clear_i    = 1'b0;
    evt_rptr_i     = '0;
    repeat (8) @(negedge clk_i);
    arst_n_i   = 1'b1;
    fmt_chk_en = 1'b1;
    run_event_order();
    run_back_pressure();
    run_formatting();
    run_watermark();
    run_trigger();
    $display("summary: 5 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

/* trace_export_top.f */
+incdir+.
trace_export_pkg.sv
event_cdc_src.sv
trace_formatter.sv
trace_irq_unit.sv
trace_export_top.sv
tb_trace_export.sv

/* Makefile */
# Verilator build and run of the trace export testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_export
FILELIST  ?= trace_export_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Something failed

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  build  compile $(TOP) with Verilator into $(BUILD_DIR)"
	@echo "  test   build, run and search $(LOG) for the failure message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
